// File: src/saturn_cfg.svh
// ~~~~~~~~~~~~~~~~~~~~
// Build constants for the bus core, included by the modules that size on them.
// ~~~~~~~~~~~~~~~~~~~~

`ifndef SATURN_CFG_SVH
`define SATURN_CFG_SVH

// Firmware ROM size in nibbles.
`define SATURN_ROM_DEPTH     32

// Address nibbles after LOAD_PC, LSN first (20-bit address).
`define SATURN_ADDR_NIBBLES  5

// First nibble address of the debug dump.
`define SATURN_START_ADDR    3

// Nibbles read in one run.
`define SATURN_READ_COUNT    24

// Character FIFO entries. Small on purpose so back-pressure shows up.
`define SATURN_FIFO_DEPTH    4

`endif

// File: src/saturn_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Shared types for the nibble bus core: bus opcodes, FSM states and the
// nibble to ASCII hex helper. Referenced by scoped name only.
// ~~~~~~~~~~~~~~~~~~~~

package saturn_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Bus command opcodes, sent with is_data low.
    // ~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [3:0] {
        PC_READ = 4'h4,
        LOAD_PC = 4'h5
    } bus_cmd_e;

    // Bus controller sequence.
    typedef enum logic [2:0] {
        SEND_LOAD_PC,
        SEND_ADDR,
        SEND_PC_READ,
        READ,
        NEWLINE,
        DONE
    } ctrl_state_e;

    // Serial emitter handshake.
    typedef enum logic {
        IDLE,
        SEND
    } emit_state_e;

    // ~~~~~~~~~~~~~~~~~~~~
    // Upper case hex digit for one nibble.
    // ~~~~~~~~~~~~~~~~~~~~
    function automatic logic [7:0] hex_char(input logic [3:0] nib);
        // '0' is 0x30, 'A' is 0x41 = 0x37 + 10.
        if (nib < 4'd10) begin
            return 8'h30 + {4'h0, nib};
        end
        return 8'h37 + {4'h0, nib};
    endfunction

endpackage

// File: src/saturn_nibble_bus_if.sv
// ~~~~~~~~~~~~~~~~~~~~
// Phase gated 4-bit command/data bus between the bus controller and the ROM.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

interface saturn_nibble_bus_if;

    // Transfer strobe, already qualified with phase 1 and clock enable.
    logic       bus_clk_en;
    // Low for a command nibble, high for address or read data.
    logic       is_data;
    logic [3:0] nibble_to_rom;
    // Nibble at the ROM program counter.
    logic [3:0] nibble_from_rom;

    modport ctrl (
        output bus_clk_en,
        output is_data,
        output nibble_to_rom,
        input  nibble_from_rom
    );

    modport rom (
        input  bus_clk_en,
        input  is_data,
        input  nibble_to_rom,
        output nibble_from_rom
    );

endinterface

// File: src/saturn_phase_gen.sv
// ~~~~~~~~~~~~~~~~~~~~
// Four phase sequencer. One bus cycle is phases 0..3; stall freezes the ring.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module saturn_phase_gen (
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_clk_en,
    input  logic        i_stall,
    output logic [1:0]  o_phase,
    output logic [31:0] o_cycle_ctr
);

    // One-hot ring, bit n set means phase n.
    logic [3:0] phases;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            phases      <= 4'b0001;
            o_cycle_ctr <= 32'd0;
        end else if (i_clk_en && !i_stall) begin
            phases <= {phases[2:0], phases[3]};
            // Phase 3 now means phase 0 next, so a new bus cycle starts.
            o_cycle_ctr <= o_cycle_ctr + {31'd0, phases[3]};
        end
    end

    // Decode ring to phase number.
    always_comb begin
        o_phase = 2'd0;
        if (phases[1]) begin
            o_phase = 2'd1;
        end
        if (phases[2]) begin
            o_phase = 2'd2;
        end
        if (phases[3]) begin
            o_phase = 2'd3;
        end
    end

    // Ring must never lose or duplicate its token.
    a_ring_onehot: assert property (
        @(posedge i_clk) disable iff (i_reset) $onehot(phases)
    );

endmodule

// File: src/saturn_rom.sv
// ~~~~~~~~~~~~~~~~~~~~
// Firmware ROM on the nibble bus. Keeps its own PC, loaded by LOAD_PC.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "saturn_cfg.svh"

module saturn_rom (
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic [1:0]         i_phase,
    saturn_nibble_bus_if.rom   bus
);

    localparam int AW = $clog2(`SATURN_ROM_DEPTH);

    logic [3:0]                      mem [0:`SATURN_ROM_DEPTH-1];
    logic [4*`SATURN_ADDR_NIBBLES-1:0] pc;
    // Next address nibble slot while loading the PC.
    logic [2:0]                      addr_idx;
    saturn_pkg::bus_cmd_e            last_cmd;
    logic                            xfer;

    initial begin
        $readmemh("rom.hex", mem);
    end

    // Transfer edge, phase 1 only.
    assign xfer = bus.bus_clk_en && (i_phase == 2'd1);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc       <= '0;
            addr_idx <= 3'd0;
            last_cmd <= saturn_pkg::PC_READ;
        end else if (xfer) begin
            if (!bus.is_data) begin
                // New command, restart address assembly.
                last_cmd <= saturn_pkg::bus_cmd_e'(bus.nibble_to_rom);
                addr_idx <= 3'd0;
            end else if (last_cmd == saturn_pkg::LOAD_PC) begin
                // Address arrives LSN first.
                pc[{addr_idx, 2'b00} +: 4] <= bus.nibble_to_rom;
                addr_idx                   <= addr_idx + 3'd1;
            end else begin
                // Read, step to the next nibble.
                pc <= pc + 1'b1;
            end
        end
    end

    // Read data is combinational from the PC.
    assign bus.nibble_from_rom = mem[pc[AW-1:0]];

    // Only the two decoded opcodes may be issued by the controller.
    a_known_cmd: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (xfer && !bus.is_data) |->
            (bus.nibble_to_rom inside {saturn_pkg::LOAD_PC, saturn_pkg::PC_READ})
    );

endmodule

// File: src/saturn_bus_controller.sv
// ~~~~~~~~~~~~~~~~~~~~
// Bus master. Loads the ROM PC, reads a run of nibbles and pushes them
// as hex characters plus a newline into the debug character FIFO.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "saturn_cfg.svh"

module saturn_bus_controller (
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               i_clk_en,
    input  logic [1:0]         i_phase,
    input  logic               i_fifo_full,
    output logic               o_stall,
    output logic               o_push,
    output logic [7:0]         o_push_char,
    output logic               o_done,
    saturn_nibble_bus_if.ctrl  bus
);

    localparam int RCW = $clog2(`SATURN_READ_COUNT);
    localparam logic [4*`SATURN_ADDR_NIBBLES-1:0] START_ADDR = `SATURN_START_ADDR;

    saturn_pkg::ctrl_state_e state;
    logic [2:0]              addr_cnt;
    logic [RCW-1:0]          read_cnt;
    // Character producing states.
    logic                    has_char;
    // Bus cycle actually completes this edge.
    logic                    step;

    // ~~~~~~~~~~~~~~~~~~~~
    // Stall and step
    // ~~~~~~~~~~~~~~~~~~~~

    assign has_char = (state == saturn_pkg::READ) || (state == saturn_pkg::NEWLINE);

    // Hold phase 1 while a character cannot be pushed.
    assign o_stall = (i_phase == 2'd1) && has_char && i_fifo_full;

    assign step = i_clk_en && (i_phase == 2'd1) && !o_stall && (state != saturn_pkg::DONE);

    // ~~~~~~~~~~~~~~~~~~~~
    // Bus and FIFO drive
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        bus.bus_clk_en    = 1'b0;
        bus.is_data       = 1'b0;
        bus.nibble_to_rom = 4'h0;
        case (state)
            saturn_pkg::SEND_LOAD_PC: begin
                bus.bus_clk_en    = step;
                bus.nibble_to_rom = saturn_pkg::LOAD_PC;
            end
            saturn_pkg::SEND_ADDR: begin
                bus.bus_clk_en    = step;
                bus.is_data       = 1'b1;
                bus.nibble_to_rom = START_ADDR[{addr_cnt, 2'b00} +: 4];
            end
            saturn_pkg::SEND_PC_READ: begin
                bus.bus_clk_en    = step;
                bus.nibble_to_rom = saturn_pkg::PC_READ;
            end
            saturn_pkg::READ: begin
                // Data read. The ROM ignores nibble_to_rom here.
                bus.bus_clk_en = step;
                bus.is_data    = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // Push lands on the same edge as the read.
    assign o_push      = step && has_char;
    assign o_push_char = (state == saturn_pkg::NEWLINE) ? 8'h0A
                                                        : saturn_pkg::hex_char(bus.nibble_from_rom);
    assign o_done      = (state == saturn_pkg::DONE);

    // ~~~~~~~~~~~~~~~~~~~~
    // Sequence
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state    <= saturn_pkg::SEND_LOAD_PC;
            addr_cnt <= 3'd0;
            read_cnt <= '0;
        end else if (step) begin
            case (state)
                saturn_pkg::SEND_LOAD_PC: begin
                    state    <= saturn_pkg::SEND_ADDR;
                    addr_cnt <= 3'd0;
                end
                saturn_pkg::SEND_ADDR: begin
                    addr_cnt <= addr_cnt + 3'd1;
                    if (addr_cnt == 3'(`SATURN_ADDR_NIBBLES - 1)) begin
                        state <= saturn_pkg::SEND_PC_READ;
                    end
                end
                saturn_pkg::SEND_PC_READ: begin
                    state    <= saturn_pkg::READ;
                    read_cnt <= '0;
                end
                saturn_pkg::READ: begin
                    read_cnt <= read_cnt + 1'b1;
                    if (read_cnt == RCW'(`SATURN_READ_COUNT - 1)) begin
                        state <= saturn_pkg::NEWLINE;
                    end
                end
                saturn_pkg::NEWLINE: begin
                    state <= saturn_pkg::DONE;
                end
                default: begin
                    state <= saturn_pkg::DONE;
                end
            endcase
        end
    end

    // Pushed characters come from a loaded ROM image.
    a_push_char_known: assert property (
        @(posedge i_clk) disable iff (i_reset) o_push |-> !$isunknown(o_push_char)
    );

endmodule

// File: src/saturn_char_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~
// Small synchronous FIFO for debug characters.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "saturn_cfg.svh"

module saturn_char_fifo (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_push,
    input  logic [7:0] i_push_char,
    input  logic       i_pop,
    output logic       o_full,
    output logic       o_empty,
    output logic [7:0] o_head_char
);

    localparam int AW = $clog2(`SATURN_FIFO_DEPTH);

    logic [7:0]  mem [0:`SATURN_FIFO_DEPTH-1];
    // Extra top bit tells full from empty.
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage.
    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[wr_ptr[AW-1:0]] <= i_push_char;
        end
    end

    assign o_empty     = (wr_ptr == rd_ptr);
    assign o_full      = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign o_head_char = mem[rd_ptr[AW-1:0]];

    a_no_overflow: assert property (
        @(posedge i_clk) disable iff (i_reset) i_push |-> !o_full
    );

    a_no_underflow: assert property (
        @(posedge i_clk) disable iff (i_reset) i_pop |-> !o_empty
    );

endmodule

// File: src/saturn_serial_emitter.sv
// ~~~~~~~~~~~~~~~~~~~~
// Drains the character FIFO into the external UART, one send pulse per char.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module saturn_serial_emitter (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_empty,
    input  logic [7:0] i_head_char,
    input  logic       i_serial_busy,
    output logic       o_pop,
    output logic [7:0] o_char_to_send,
    output logic       o_char_valid,
    output logic       o_char_send,
    output logic [9:0] o_char_counter
);

    saturn_pkg::emit_state_e state;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state          <= saturn_pkg::IDLE;
            o_char_counter <= 10'd0;
        end else begin
            case (state)
                saturn_pkg::IDLE: begin
                    if (!i_empty) begin
                        state <= saturn_pkg::SEND;
                    end
                end
                default: begin
                    // Wait out UART busy, then hand over.
                    if (!i_serial_busy) begin
                        state          <= saturn_pkg::IDLE;
                        o_char_counter <= o_char_counter + 10'd1;
                    end
                end
            endcase
        end
    end

    // Capture the head while idle. Stable until the pop anyway.
    always_ff @(posedge i_clk) begin
        if ((state == saturn_pkg::IDLE) && !i_empty) begin
            o_char_to_send <= i_head_char;
        end
    end

    assign o_char_valid = (state == saturn_pkg::SEND);
    // First free cycle of the UART.
    assign o_char_send  = o_char_valid && !i_serial_busy;
    assign o_pop        = o_char_send;

endmodule

// File: src/saturn_bus.sv
// ~~~~~~~~~~~~~~~~~~~~
// Top level of the nibble bus core. Plain ports toward the UART and host.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module saturn_bus (
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_clk_en,
    input  logic        i_serial_busy,
    output logic        o_halt,
    output logic [1:0]  o_phase,
    output logic [31:0] o_cycle_ctr,
    output logic [7:0]  o_char_to_send,
    output logic        o_char_valid,
    output logic        o_char_send,
    output logic [9:0]  o_char_counter
);

    logic       stall;
    logic       ctrl_done;
    logic       fifo_push;
    logic [7:0] fifo_push_char;
    logic       fifo_full;
    logic       fifo_empty;
    logic       fifo_pop;
    logic [7:0] fifo_head_char;

    saturn_nibble_bus_if nibble_bus ();

    // ~~~~~~~~~~~~~~~~~~~~
    // Bus side
    // ~~~~~~~~~~~~~~~~~~~~

    saturn_phase_gen u_phase_gen (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_clk_en    (i_clk_en),
        .i_stall     (stall),
        .o_phase     (o_phase),
        .o_cycle_ctr (o_cycle_ctr)
    );

    saturn_rom u_rom (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_phase (o_phase),
        .bus     (nibble_bus.rom)
    );

    saturn_bus_controller u_bus_controller (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_clk_en    (i_clk_en),
        .i_phase     (o_phase),
        .i_fifo_full (fifo_full),
        .o_stall     (stall),
        .o_push      (fifo_push),
        .o_push_char (fifo_push_char),
        .o_done      (ctrl_done),
        .bus         (nibble_bus.ctrl)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Debug character path
    // ~~~~~~~~~~~~~~~~~~~~

    saturn_char_fifo u_char_fifo (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_push      (fifo_push),
        .i_push_char (fifo_push_char),
        .i_pop       (fifo_pop),
        .o_full      (fifo_full),
        .o_empty     (fifo_empty),
        .o_head_char (fifo_head_char)
    );

    saturn_serial_emitter u_serial_emitter (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_empty        (fifo_empty),
        .i_head_char    (fifo_head_char),
        .i_serial_busy  (i_serial_busy),
        .o_pop          (fifo_pop),
        .o_char_to_send (o_char_to_send),
        .o_char_valid   (o_char_valid),
        .o_char_send    (o_char_send),
        .o_char_counter (o_char_counter)
    );

    // Run is over once the last character has left the FIFO.
    assign o_halt = ctrl_done && fifo_empty;

endmodule

// File: dv/tb_saturn_model.sv
// ~~~~~~~~~~~~~~~~~~~~
// Reference model of the debug character stream, built from the ROM image.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "saturn_cfg.svh"

module tb_saturn_model (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_char_send,
    input  logic [7:0] i_char_to_send,
    output logic [9:0] o_sent,
    output logic [7:0] o_exp_char,
    output logic       o_char_ok,
    output logic       o_all_sent
);

    // Hex digits of the read run, then one newline.
    localparam int TOTAL = `SATURN_READ_COUNT + 1;

    logic [3:0] rom [0:`SATURN_ROM_DEPTH-1];
    logic [7:0] expected [0:TOTAL-1];

    // ASCII upper case hex digit, straight from the character table.
    function automatic logic [7:0] ascii_hex(input logic [3:0] nib);
        logic [7:0] digit;
        if (nib <= 4'd9) begin
            digit = "0" + {4'h0, nib};
        end else begin
            digit = "A" + {4'h0, nib} - 8'd10;
        end
        return digit;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Expected stream
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        int i;
        $readmemh("rom.hex", rom);
        for (i = 0; i < `SATURN_READ_COUNT; i++) begin
            expected[i] = ascii_hex(rom[`SATURN_START_ADDR + i]);
        end
        // Run closes with a line feed.
        expected[TOTAL-1] = 8'h0A;
    end

    // Send pulses seen so far, counted on the edge that takes them.
    always @(posedge i_clk) begin
        if (i_reset) begin
            o_sent <= 10'd0;
        end else if (i_char_send) begin
            o_sent <= o_sent + 10'd1;
        end
    end

    assign o_exp_char = (o_sent < 10'(TOTAL)) ? expected[o_sent] : 8'h00;

    // A pulse must carry the next character, and only while some are left.
    assign o_char_ok  = !i_char_send ||
                        ((o_sent < 10'(TOTAL)) && (i_char_to_send == o_exp_char));
    assign o_all_sent = (o_sent == 10'(TOTAL));

endmodule

// File: dv/tb_saturn_bus.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench top for the nibble bus core. Drives random clock enable and UART busy
// and checks on the falling edge against the character model.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "saturn_cfg.svh"

module tb_saturn_bus;

    localparam int TOTAL            = `SATURN_READ_COUNT + 1;
    localparam int RESET_CYCLES     = 16;
    // Each of the 25 characters gets 4 phases with a margin of 40 for stalls.
    localparam int TIMEOUT_CYCLES   = TOTAL * 4 * 40;
    localparam int POST_HALT_CYCLES = 32;

    logic        clk;
    logic        reset;
    logic        clk_en;
    logic        serial_busy;
    logic        halt;
    logic [1:0]  phase;
    logic [31:0] cycle_ctr;
    logic [7:0]  char_to_send;
    logic        char_valid;
    logic        char_send;
    logic [9:0]  char_counter;

    logic [9:0]  sent;
    logic [7:0]  exp_char;
    logic        char_ok;
    logic        all_sent;

    // Falling edge history for the phase and counter checks.
    logic        have_prev;
    logic [1:0]  prev_phase;
    logic [1:0]  next_phase;
    logic [31:0] prev_ctr;
    logic        prev_clk_en;
    logic        prev_valid;
    logic        prev_send;
    logic [7:0]  prev_char;
    logic        halt_seen;
    int unsigned cycle_count;

    saturn_bus saturn_bus_i (
        .i_clk          (clk),
        .i_reset        (reset),
        .i_clk_en       (clk_en),
        .i_serial_busy  (serial_busy),
        .o_halt         (halt),
        .o_phase        (phase),
        .o_cycle_ctr    (cycle_ctr),
        .o_char_to_send (char_to_send),
        .o_char_valid   (char_valid),
        .o_char_send    (char_send),
        .o_char_counter (char_counter)
    );

    tb_saturn_model model_i (
        .i_clk          (clk),
        .i_reset        (reset),
        .i_char_send    (char_send),
        .i_char_to_send (char_to_send),
        .o_sent         (sent),
        .o_exp_char     (exp_char),
        .o_char_ok      (char_ok),
        .o_all_sent     (all_sent)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Clock and timeout
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    initial begin
        cycle_count = 0;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout: the run did not finish within %0d clock cycles",
                               TIMEOUT_CYCLES));
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        int unsigned burst_left;
        int unsigned tail_left;
        void'($urandom(80));
        reset       = 1'b1;
        clk_en      = 1'b0;
        serial_busy = 1'b0;
        burst_left  = 0;
        tail_left   = POST_HALT_CYCLES;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        // Reset values are checked while reset is still held.
        @(negedge clk);
        assert ((phase == 2'd0) && (cycle_ctr == 32'd0) && (char_counter == 10'd0) &&
                !char_valid && !char_send && !halt)
        else fail_run($sformatf("error at %0t: bad reset state phase %0d ctr %0d chars %0d",
                                $time, phase, cycle_ctr, char_counter));
        @(posedge clk);
        reset <= 1'b0;
        while (tail_left != 0) begin
            @(posedge clk);
            // Clock enable high about three cycles in four.
            clk_en <= (($urandom % 4) != 0);
            // Busy comes in bursts that can back up the FIFO.
            if (burst_left != 0) begin
                serial_busy <= 1'b1;
                burst_left  = burst_left - 1;
            end else if (($urandom % 16) == 0) begin
                serial_busy <= 1'b1;
                burst_left  = $urandom % 40;
            end else begin
                serial_busy <= 1'b0;
            end
            if (halt_seen) begin
                tail_left = tail_left - 1;
            end
        end
        @(negedge clk);
        assert (halt && all_sent && (char_counter == 10'(TOTAL)))
        else fail_run($sformatf("error at %0t: run ended with %0d characters, expected %0d",
                                $time, char_counter, TOTAL));
        $display("Done: no errors");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin
        if (reset) begin
            have_prev = 1'b0;
            halt_seen = 1'b0;
        end else begin
            assert (!(char_send && serial_busy))
            else fail_run($sformatf("error at %0t: send pulse while UART busy", $time));
            assert (!char_send || char_valid)
            else fail_run($sformatf("error at %0t: send pulse without a valid character",
                                    $time));
            // A valid character goes out in the first cycle the UART is free.
            if (char_valid && !serial_busy) begin
                assert (char_send)
                else fail_run($sformatf("error at %0t: UART free but no send pulse", $time));
            end
            assert (char_ok)
            else fail_run($sformatf("error at %0t: char %0d is %h, expected %h",
                                    $time, sent, char_to_send, exp_char));
            assert (char_counter == sent)
            else fail_run($sformatf("error at %0t: char counter %0d, pulses seen %0d",
                                    $time, char_counter, sent));
            if (have_prev) begin
                next_phase = prev_phase + 2'd1;
                // Phase moves only on an enabled edge, and then by one at most.
                if (prev_clk_en) begin
                    assert ((phase == prev_phase) || (phase == next_phase))
                    else fail_run($sformatf("error at %0t: phase %0d after %0d",
                                            $time, phase, prev_phase));
                end else begin
                    assert (phase == prev_phase)
                    else fail_run($sformatf("error at %0t: phase moved without clock enable",
                                            $time));
                end
                // Bus cycle count follows the 3 to 0 wrap only.
                if ((prev_phase == 2'd3) && (phase == 2'd0)) begin
                    assert (cycle_ctr == prev_ctr + 32'd1)
                    else fail_run($sformatf("error at %0t: cycle ctr %0d on wrap, was %0d",
                                            $time, cycle_ctr, prev_ctr));
                end else begin
                    assert (cycle_ctr == prev_ctr)
                    else fail_run($sformatf("error at %0t: cycle ctr %0d without wrap, was %0d",
                                            $time, cycle_ctr, prev_ctr));
                end
                // A presented character waits unchanged until it is sent.
                if (prev_valid && !prev_send) begin
                    assert (char_valid && (char_to_send == prev_char))
                    else fail_run($sformatf("error at %0t: char %h withdrawn before send",
                                            $time, prev_char));
                end
            end
            if (halt) begin
                assert (all_sent && (char_counter == 10'(TOTAL)) && !char_send)
                else fail_run($sformatf("error at %0t: halt with %0d characters sent",
                                        $time, char_counter));
                halt_seen = 1'b1;
            end else begin
                assert (!halt_seen)
                else fail_run($sformatf("error at %0t: halt dropped after the run ended",
                                        $time));
            end
            prev_phase  = phase;
            prev_ctr    = cycle_ctr;
            prev_clk_en = clk_en;
            prev_valid  = char_valid;
            prev_send   = char_send;
            prev_char   = char_to_send;
            have_prev   = 1'b1;
        end
    end

endmodule

// File: rom.hex
// Firmware nibble image: one hex nibble per line, address 0 at the top.
0
3
1
F
A
2
9
C
5
7
E
B
4
8
D
6
0
1
F
3
C
A
2
9
5
E
7
B
6
8
D
4

// File: tb.f
+incdir+src
src/saturn_pkg.sv
src/saturn_nibble_bus_if.sv
src/saturn_phase_gen.sv
src/saturn_rom.sv
src/saturn_bus_controller.sv
src/saturn_char_fifo.sv
src/saturn_serial_emitter.sv
src/saturn_bus.sv
dv/tb_saturn_model.sv
dv/tb_saturn_bus.sv
